//--- dbg_pkg.sv
`default_nettype none

package dbg_pkg;

  // Widths the struct fields are built on; the top level checks its parameters against them
  localparam int NUM_LANES_C   = 16;
  localparam int LANE_W_C      = 12;
  localparam int WH_ADDR_W_C   = 14;
  localparam int FEAT_ADDR_W_C = 16;
  localparam int LANE_SEL_W_C  = $clog2(NUM_LANES_C);

  localparam logic [31:0] DBG_ID = 32'd15302503;

  typedef enum logic [3:0] {
    REG_ID        = 4'd0,
    REG_CONFIG    = 4'd1,
    REG_STATUS    = 4'd2,
    REG_CTRL      = 4'd3,
    REG_MATCH_A   = 4'd4,
    REG_MATCH_B   = 4'd5,
    REG_LANE_SEL  = 4'd6,
    REG_EVT_COUNT = 4'd7,
    REG_SAMPLE_A  = 4'd8,
    REG_SAMPLE_B  = 4'd9,
    REG_NONE      = 4'd15
  } dbg_reg_e;

  // APB byte offsets
  localparam logic [7:0] OFF_ID        = 8'h00;
  localparam logic [7:0] OFF_CONFIG    = 8'h04;
  localparam logic [7:0] OFF_STATUS    = 8'h08;
  localparam logic [7:0] OFF_CTRL      = 8'h0C;
  localparam logic [7:0] OFF_MATCH_A   = 8'h10;
  localparam logic [7:0] OFF_MATCH_B   = 8'h14;
  localparam logic [7:0] OFF_LANE_SEL  = 8'h18;
  localparam logic [7:0] OFF_EVT_COUNT = 8'h1C;
  localparam logic [7:0] OFF_SAMPLE_A  = 8'h20;
  localparam logic [7:0] OFF_SAMPLE_B  = 8'h24;

  typedef struct packed {
    logic spmm_vld; // Bit 7 of STATUS
    logic spmm_rdy;
    logic dmvm_vld;
    logic dmvm_rdy;
    logic sm_vld;
    logic sm_rdy;
    logic aggr_vld;
    logic aggr_rdy; // Bit 0 of STATUS
  } stage_hs_t;

  typedef struct packed {
    logic [WH_ADDR_W_C-1:0]  match_a;
    logic [WH_ADDR_W_C-1:0]  match_b;
    logic [LANE_SEL_W_C-1:0] lane_sel;
  } dbg_cfg_t;

  typedef struct packed {
    logic      feat_hi_seen;
    logic      feat_ena_seen;
    stage_hs_t stages;
  } dbg_status_t;

  typedef struct packed {
    dbg_status_t         status;
    logic [31:0]         evt_count;
    logic [LANE_W_C-1:0] sample_a;
    logic [LANE_W_C-1:0] sample_b;
  } dbg_state_t;

endpackage

`default_nettype wire

//--- dbg_apb_decode.sv
`default_nettype none

module dbg_apb_decode #(
  parameter int WH_ADDR_W = 14
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic [7:0]        paddr_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [31:0]       pwdata_i,
  output logic              pready_o,
  output logic              pslverr_o,
  output dbg_pkg::dbg_cfg_t cfg_o,
  output logic              clr_o,
  output dbg_pkg::dbg_reg_e reg_sel_o
);

  dbg_pkg::dbg_reg_e addr_sel;
  logic              read_only;
  logic              setup;
  logic              access;
  logic              err_q;
  logic              wr_done;

  assign setup   = psel_i && !penable_i;
  assign access  = psel_i && penable_i;
  assign wr_done = access && pready_o && pwrite_i && !pslverr_o;

  always_comb begin
    case (paddr_i)
      dbg_pkg::OFF_ID:        addr_sel = dbg_pkg::REG_ID;
      dbg_pkg::OFF_CONFIG:    addr_sel = dbg_pkg::REG_CONFIG;
      dbg_pkg::OFF_STATUS:    addr_sel = dbg_pkg::REG_STATUS;
      dbg_pkg::OFF_CTRL:      addr_sel = dbg_pkg::REG_CTRL;
      dbg_pkg::OFF_MATCH_A:   addr_sel = dbg_pkg::REG_MATCH_A;
      dbg_pkg::OFF_MATCH_B:   addr_sel = dbg_pkg::REG_MATCH_B;
      dbg_pkg::OFF_LANE_SEL:  addr_sel = dbg_pkg::REG_LANE_SEL;
      dbg_pkg::OFF_EVT_COUNT: addr_sel = dbg_pkg::REG_EVT_COUNT;
      dbg_pkg::OFF_SAMPLE_A:  addr_sel = dbg_pkg::REG_SAMPLE_A;
      dbg_pkg::OFF_SAMPLE_B:  addr_sel = dbg_pkg::REG_SAMPLE_B;
      default:                addr_sel = dbg_pkg::REG_NONE;
    endcase
  end

  // Only CTRL and the three configuration registers accept writes
  assign read_only = !(addr_sel inside {dbg_pkg::REG_CTRL, dbg_pkg::REG_MATCH_A,
                                        dbg_pkg::REG_MATCH_B, dbg_pkg::REG_LANE_SEL});

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_sel_o <= dbg_pkg::REG_NONE;
      err_q     <= 1'b0;
    end else if (setup) begin
      reg_sel_o <= addr_sel;
      err_q     <= (addr_sel == dbg_pkg::REG_NONE) || (pwrite_i && read_only);
    end
  end

  // One wait state, then complete
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pready_o  <= 1'b0;
      pslverr_o <= 1'b0;
    end else begin
      pready_o  <= access && !pready_o;
      pslverr_o <= access && !pready_o && err_q;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg_o <= '0;
      clr_o <= 1'b0;
    end else begin
      clr_o <= wr_done && (reg_sel_o == dbg_pkg::REG_CTRL) && pwdata_i[0];
      if (wr_done) begin
        case (reg_sel_o)
          dbg_pkg::REG_MATCH_A:  cfg_o.match_a  <= pwdata_i[WH_ADDR_W-1:0];
          dbg_pkg::REG_MATCH_B:  cfg_o.match_b  <= pwdata_i[WH_ADDR_W-1:0];
          dbg_pkg::REG_LANE_SEL: cfg_o.lane_sel <= pwdata_i[dbg_pkg::LANE_SEL_W_C-1:0];
          default: ;
        endcase
      end
    end
  end

  a_penable_after_setup: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(penable_i) |-> psel_i && $past(psel_i))
    else $error("penable raised without a preceding setup phase");

  a_paddr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    access |-> $stable(paddr_i))
    else $error("paddr changed during the access phase");

endmodule

`default_nettype wire

//--- dbg_stage_flags.sv
`default_nettype none

module dbg_stage_flags #(
  parameter int FEAT_ADDR_W = 16,
  parameter int FEAT_LIMIT  = 43328
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  dbg_pkg::stage_hs_t     hs_i,
  input  logic                   feat_ena_i,
  input  logic [FEAT_ADDR_W-1:0] feat_addr_i,
  input  logic                   clr_i,
  output dbg_pkg::dbg_status_t   status_o
);

  logic feat_hi;

  // High feature writes only count while the memory is enabled
  assign feat_hi = feat_ena_i && (feat_addr_i >= FEAT_ADDR_W'(FEAT_LIMIT));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_o <= '0;
    end else if (clr_i) begin
      status_o <= '0;                                        // Clear beats a same-edge event
    end else begin
      status_o.stages        <= status_o.stages | hs_i;      // Sticky OR per stage
      status_o.feat_ena_seen <= status_o.feat_ena_seen | feat_ena_i;
      status_o.feat_hi_seen  <= status_o.feat_hi_seen | feat_hi;
    end
  end

endmodule

`default_nettype wire

//--- dbg_probe_capture.sv
`default_nettype none

module dbg_probe_capture #(
  parameter int NUM_LANES = 16,
  parameter int LANE_W    = 12,
  parameter int WH_ADDR_W = 14
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             sm_vld_i,
  input  logic                             spmm_rdy_i,
  input  logic [WH_ADDR_W-1:0]             wh_addr_i,
  input  logic [NUM_LANES-1:0][LANE_W-1:0] sppe_i,
  input  dbg_pkg::dbg_cfg_t                cfg_i,
  input  logic                             clr_i,
  output logic [31:0]                      evt_count_o,
  output logic [LANE_W-1:0]                sample_a_o,
  output logic [LANE_W-1:0]                sample_b_o
);

  logic              hit_a;
  logic              hit_b;
  logic [LANE_W-1:0] lane;

  assign hit_a = spmm_rdy_i && (wh_addr_i == cfg_i.match_a);
  assign hit_b = spmm_rdy_i && (wh_addr_i == cfg_i.match_b);
  assign lane  = sppe_i[cfg_i.lane_sel];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      evt_count_o <= '0;
    end else if (clr_i) begin
      evt_count_o <= '0;
    end else if (sm_vld_i) begin
      evt_count_o <= evt_count_o + 32'd1; // Wraps at 2^32
    end
  end

  // Both samples may load on the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sample_a_o <= '0;
      sample_b_o <= '0;
    end else if (clr_i) begin
      sample_a_o <= '0;
      sample_b_o <= '0;
    end else begin
      if (hit_a) begin
        sample_a_o <= lane;
      end
      if (hit_b) begin
        sample_b_o <= lane;
      end
    end
  end

endmodule

`default_nettype wire

//--- dbg_readout.sv
`default_nettype none

module dbg_readout #(
  parameter int H_NUM_SPARSE_DATA = 12
) (
  input  dbg_pkg::dbg_reg_e   reg_sel_i,
  input  dbg_pkg::dbg_cfg_t   cfg_i,
  input  dbg_pkg::dbg_state_t state_i,
  output logic [31:0]         prdata_o
);

  always_comb begin
    case (reg_sel_i)
      dbg_pkg::REG_ID:        prdata_o = dbg_pkg::DBG_ID;
      dbg_pkg::REG_CONFIG:    prdata_o = 32'(H_NUM_SPARSE_DATA);
      dbg_pkg::REG_STATUS:    prdata_o = 32'(state_i.status);  // {hi, ena, stages}
      dbg_pkg::REG_MATCH_A:   prdata_o = 32'(cfg_i.match_a);
      dbg_pkg::REG_MATCH_B:   prdata_o = 32'(cfg_i.match_b);
      dbg_pkg::REG_LANE_SEL:  prdata_o = 32'(cfg_i.lane_sel);
      dbg_pkg::REG_EVT_COUNT: prdata_o = state_i.evt_count;
      dbg_pkg::REG_SAMPLE_A:  prdata_o = 32'(state_i.sample_a);
      dbg_pkg::REG_SAMPLE_B:  prdata_o = 32'(state_i.sample_b);
      default:                prdata_o = '0;                    // CTRL and unmapped
    endcase
  end

endmodule

`default_nettype wire

//--- dbg_monitor_top.sv
`default_nettype none

module dbg_monitor_top #(
  parameter int NUM_LANES         = 16,
  parameter int LANE_W            = 12,
  parameter int WH_ADDR_W         = 14,
  parameter int FEAT_ADDR_W       = 16,
  parameter int FEAT_LIMIT        = 43328,
  parameter int H_NUM_SPARSE_DATA = 12
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [7:0]                       paddr_i,
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [31:0]                      pwdata_i,
  output logic [31:0]                      prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,
  input  dbg_pkg::stage_hs_t               hs_i,
  input  logic                             feat_ena_i,
  input  logic [FEAT_ADDR_W-1:0]           feat_addr_i,
  input  logic [WH_ADDR_W-1:0]             wh_addr_i,
  input  logic [NUM_LANES-1:0][LANE_W-1:0] sppe_i
);

  if (NUM_LANES != dbg_pkg::NUM_LANES_C || LANE_W != dbg_pkg::LANE_W_C ||
      WH_ADDR_W != dbg_pkg::WH_ADDR_W_C || FEAT_ADDR_W != dbg_pkg::FEAT_ADDR_W_C) begin : g_chk
    $error("Monitor parameters disagree with the field widths in dbg_pkg");
  end

  dbg_pkg::dbg_cfg_t    cfg;
  dbg_pkg::dbg_reg_e    reg_sel;
  dbg_pkg::dbg_state_t  state;
  dbg_pkg::dbg_status_t status;
  logic                 clr;
  logic [31:0]          evt_count;
  logic [LANE_W-1:0]    sample_a;
  logic [LANE_W-1:0]    sample_b;

  dbg_apb_decode #(
    .WH_ADDR_W (WH_ADDR_W)
  ) dbg_apb_decode_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .cfg_o     (cfg),
    .clr_o     (clr),
    .reg_sel_o (reg_sel)
  );

  dbg_stage_flags #(
    .FEAT_ADDR_W (FEAT_ADDR_W),
    .FEAT_LIMIT  (FEAT_LIMIT)
  ) dbg_stage_flags_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .hs_i        (hs_i),
    .feat_ena_i  (feat_ena_i),
    .feat_addr_i (feat_addr_i),
    .clr_i       (clr),
    .status_o    (status)
  );

  dbg_probe_capture #(
    .NUM_LANES (NUM_LANES),
    .LANE_W    (LANE_W),
    .WH_ADDR_W (WH_ADDR_W)
  ) dbg_probe_capture_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .sm_vld_i    (hs_i.sm_vld),
    .spmm_rdy_i  (hs_i.spmm_rdy),
    .wh_addr_i   (wh_addr_i),
    .sppe_i      (sppe_i),
    .cfg_i       (cfg),
    .clr_i       (clr),
    .evt_count_o (evt_count),
    .sample_a_o  (sample_a),
    .sample_b_o  (sample_b)
  );

  assign state.status    = status;
  assign state.evt_count = evt_count;
  assign state.sample_a  = sample_a;
  assign state.sample_b  = sample_b;

  dbg_readout #(
    .H_NUM_SPARSE_DATA (H_NUM_SPARSE_DATA)
  ) dbg_readout_i (
    .reg_sel_i (reg_sel),
    .cfg_i     (cfg),
    .state_i   (state),
    .prdata_o  (prdata_o)
  );

endmodule

`default_nettype wire

//--- tb_dbg_monitor.sv
`default_nettype none

module tb_dbg_monitor;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          H_NUM_SPARSE_DATA = 12;
  localparam int          FEAT_LIMIT        = 43328;
  localparam logic [31:0] ID_WORD           = 32'd15302503;

  localparam int MODE_FLAGS  = 0;
  localparam int MODE_COUNT  = 1;
  localparam int MODE_SAMPLE = 2;

  localparam int RST_CYC     = 4;
  localparam int STAT_BURSTS = 10;
  localparam int STAT_CYC    = 12;
  localparam int CNT_CYC     = 300;
  localparam int SAMP_ROUNDS = 2;
  localparam int SAMP_CYC    = 200;
  localparam int APB_XFERS   = 64;
  localparam int APB_CYC     = 4;
  localparam int TEST_CYC    = RST_CYC + (STAT_BURSTS + 2) * STAT_CYC + CNT_CYC
                             + SAMP_ROUNDS * SAMP_CYC + APB_XFERS * APB_CYC;
  localparam int TIMEOUT_CYC = 2 * TEST_CYC;

  logic                  clk;
  logic                  rst_n;
  logic [7:0]            paddr;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [31:0]           pwdata;
  logic [31:0]           prdata;
  logic                  pready;
  logic                  pslverr;
  dbg_pkg::stage_hs_t    hs;
  logic                  feat_ena;
  logic [15:0]           feat_addr;
  logic [13:0]           wh_addr;
  logic [15:0][11:0]     sppe;

  logic [31:0] lfsr_q = 32'd94308;
  int          cycles = 0;
  logic [7:0]  cur_addr;
  logic        cur_write;
  logic        pend_wr;

  // Register file model
  logic [7:0]  m_stages;
  logic        m_ena_seen;
  logic        m_hi_seen;
  logic [31:0] m_count;
  logic [11:0] m_sample_a;
  logic [11:0] m_sample_b;
  logic [13:0] m_match_a;
  logic [13:0] m_match_b;
  logic [3:0]  m_lane_sel;
  logic        clr_due;

  logic [7:0] unmapped_offs [4] = '{8'h28, 8'h3C, 8'h02, 8'hFC};
  logic [7:0] ro_offs [6] = '{dbg_pkg::OFF_ID, dbg_pkg::OFF_CONFIG, dbg_pkg::OFF_STATUS,
                              dbg_pkg::OFF_EVT_COUNT, dbg_pkg::OFF_SAMPLE_A,
                              dbg_pkg::OFF_SAMPLE_B};

  dbg_monitor_top dbg_monitor_top_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .paddr_i     (paddr),
    .psel_i      (psel),
    .penable_i   (penable),
    .pwrite_i    (pwrite),
    .pwdata_i    (pwdata),
    .prdata_o    (prdata),
    .pready_o    (pready),
    .pslverr_o   (pslverr),
    .hs_i        (hs),
    .feat_ena_i  (feat_ena),
    .feat_addr_i (feat_addr),
    .wh_addr_i   (wh_addr),
    .sppe_i      (sppe)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic rare_bit();
    return rand_bits(3) == 32'd7; // One in eight
  endfunction

  function automatic logic [31:0] ref_read(input logic [7:0] addr);
    case (addr)
      dbg_pkg::OFF_ID:        return ID_WORD;
      dbg_pkg::OFF_CONFIG:    return 32'(H_NUM_SPARSE_DATA);
      dbg_pkg::OFF_STATUS:    return {22'd0, m_hi_seen, m_ena_seen, m_stages};
      dbg_pkg::OFF_MATCH_A:   return {18'd0, m_match_a};
      dbg_pkg::OFF_MATCH_B:   return {18'd0, m_match_b};
      dbg_pkg::OFF_LANE_SEL:  return {28'd0, m_lane_sel};
      dbg_pkg::OFF_EVT_COUNT: return m_count;
      dbg_pkg::OFF_SAMPLE_A:  return {20'd0, m_sample_a};
      dbg_pkg::OFF_SAMPLE_B:  return {20'd0, m_sample_b};
      default:                return 32'd0; // CTRL and holes
    endcase
  endfunction

  function automatic logic ref_err(input logic [7:0] addr, input logic write);
    case (addr)
      dbg_pkg::OFF_CTRL, dbg_pkg::OFF_MATCH_A,
      dbg_pkg::OFF_MATCH_B, dbg_pkg::OFF_LANE_SEL: return 1'b0;
      dbg_pkg::OFF_ID, dbg_pkg::OFF_CONFIG, dbg_pkg::OFF_STATUS,
      dbg_pkg::OFF_EVT_COUNT, dbg_pkg::OFF_SAMPLE_A, dbg_pkg::OFF_SAMPLE_B: return write;
      default: return 1'b1;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
      $display("Some tests failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_stages   = '0;
      m_ena_seen = 1'b0;
      m_hi_seen  = 1'b0;
      m_count    = '0;
      m_sample_a = '0;
      m_sample_b = '0;
      m_match_a  = '0;
      m_match_b  = '0;
      m_lane_sel = '0;
      clr_due    = 1'b0;
    end else begin
      if (clr_due) begin
        m_stages   = '0; // Events on this edge are dropped
        m_ena_seen = 1'b0;
        m_hi_seen  = 1'b0;
        m_count    = '0;
        m_sample_a = '0;
        m_sample_b = '0;
        clr_due    = 1'b0;
      end else begin
        m_stages   = m_stages | hs;
        m_ena_seen = m_ena_seen | feat_ena;
        m_hi_seen  = m_hi_seen | (feat_ena && int'(feat_addr) >= FEAT_LIMIT);
        if (hs.sm_vld) m_count = m_count + 32'd1;
        if (hs.spmm_rdy && wh_addr == m_match_a) m_sample_a = sppe[m_lane_sel];
        if (hs.spmm_rdy && wh_addr == m_match_b) m_sample_b = sppe[m_lane_sel];
      end
      if (pend_wr) begin
        case (cur_addr)
          dbg_pkg::OFF_CTRL:     clr_due    = pwdata[0];
          dbg_pkg::OFF_MATCH_A:  m_match_a  = pwdata[13:0];
          dbg_pkg::OFF_MATCH_B:  m_match_b  = pwdata[13:0];
          dbg_pkg::OFF_LANE_SEL: m_lane_sel = pwdata[3:0];
          default: ;
        endcase
      end
    end
  end

  // Completing cycle of each transfer
  always @(negedge clk) begin
    pend_wr = 1'b0;
    if (pready) begin
      check_value($sformatf("pslverr at 0x%02h", cur_addr), {31'd0, pslverr},
                  {31'd0, ref_err(cur_addr, cur_write)});
      if (!cur_write) begin
        check_value($sformatf("prdata at 0x%02h", cur_addr), prdata, ref_read(cur_addr));
      end
      pend_wr = cur_write && !ref_err(cur_addr, 1'b1);
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYC) begin
      $display("Some tests failed");
      $fatal(1, "The run did not finish within %0d cycles", TIMEOUT_CYC);
    end
  end

  task automatic idle_inputs();
    hs        = '0;
    feat_ena  = 1'b0;
    feat_addr = '0;
    wh_addr   = '0;
    sppe      = '0;
  endtask

  task automatic apb_transfer(input logic [7:0] addr, input logic write,
                              input logic [31:0] data);
    int waits;
    @(negedge clk);
    cur_addr  = addr;
    cur_write = write;
    paddr     = addr;
    pwrite    = write;
    pwdata    = data;
    psel      = 1'b1;
    penable   = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    check_value("pready in the first access cycle", {31'd0, pready}, 32'd0);
    waits = 0;
    do begin
      @(negedge clk);
      waits = waits + 1;
    end while (!pready);
    check_value("access cycles before pready", waits, 32'd1); // One wait state
    @(negedge clk); // Completion edge has passed
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    apb_transfer(addr, 1'b1, data);
  endtask

  task automatic apb_read(input logic [7:0] addr);
    apb_transfer(addr, 1'b0, 32'd0);
  endtask

  task automatic drive_burst(input int n, input int mode);
    logic [7:0] flags;
    logic [1:0] pick;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      idle_inputs();
      case (mode)
        MODE_FLAGS: begin
          for (int s = 0; s < 8; s++) flags[s] = rare_bit();
          hs        = dbg_pkg::stage_hs_t'(flags);
          feat_ena  = rare_bit();
          feat_addr = 16'(FEAT_LIMIT - 8) + 16'(rand_bits(4)); // Straddles the limit
        end
        MODE_COUNT: hs.sm_vld = rand_bits(1) != 32'd0;
        default: begin
          hs.spmm_rdy = rand_bits(1) != 32'd0;
          pick        = 2'(rand_bits(2));
          if (pick == 2'd0) wh_addr = m_match_a;
          else if (pick == 2'd1) wh_addr = m_match_b;
          else wh_addr = 14'(rand_bits(14));
          for (int l = 0; l < 16; l++) sppe[l] = 12'(rand_bits(12));
        end
      endcase
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    cur_addr  = '0;
    cur_write = 1'b0;
    idle_inputs();
    repeat (RST_CYC) @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < 10; i++) apb_read(8'(i * 4)); // Reset values

    repeat (STAT_BURSTS) begin
      drive_burst(STAT_CYC, MODE_FLAGS);
      apb_read(dbg_pkg::OFF_STATUS);
    end

    drive_burst(CNT_CYC, MODE_COUNT);
    apb_read(dbg_pkg::OFF_EVT_COUNT);

    apb_write(dbg_pkg::OFF_MATCH_A, 32'h0000_11A5);
    apb_write(dbg_pkg::OFF_MATCH_B, 32'hFFFF_2F3C); // Upper bits dropped
    apb_write(dbg_pkg::OFF_LANE_SEL, 32'd5);
    apb_read(dbg_pkg::OFF_MATCH_A);
    apb_read(dbg_pkg::OFF_MATCH_B);
    apb_read(dbg_pkg::OFF_LANE_SEL);
    drive_burst(SAMP_CYC, MODE_SAMPLE);
    apb_read(dbg_pkg::OFF_SAMPLE_A);
    apb_read(dbg_pkg::OFF_SAMPLE_B);
    apb_write(dbg_pkg::OFF_MATCH_B, 32'h0000_11A5); // Both samples hit together
    apb_write(dbg_pkg::OFF_LANE_SEL, 32'd11);
    drive_burst(SAMP_CYC, MODE_SAMPLE);
    apb_read(dbg_pkg::OFF_SAMPLE_A);
    apb_read(dbg_pkg::OFF_SAMPLE_B);

    drive_burst(STAT_CYC, MODE_FLAGS);
    idle_inputs();
    apb_write(dbg_pkg::OFF_CTRL, 32'h2); // Bit 0 low, nothing cleared
    apb_read(dbg_pkg::OFF_STATUS);
    apb_write(dbg_pkg::OFF_CTRL, 32'h1);
    hs       = '1; // Seen only by the clearing edge
    feat_ena = 1'b1;
    @(negedge clk);
    idle_inputs();
    for (int i = 2; i < 10; i++) apb_read(8'(i * 4));

    drive_burst(STAT_CYC, MODE_SAMPLE);
    idle_inputs();
    foreach (unmapped_offs[i]) apb_read(unmapped_offs[i]);
    apb_write(8'h28, 32'hDEAD_BEEF);
    foreach (ro_offs[i]) begin
      apb_write(ro_offs[i], rand_bits(32));
      apb_read(ro_offs[i]);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
dbg_pkg.sv
dbg_apb_decode.sv
dbg_stage_flags.sv
dbg_probe_capture.sv
dbg_readout.sv
dbg_monitor_top.sv
tb_dbg_monitor.sv

//--- run.sh
#!/bin/sh
# Build and run the monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_dbg_monitor -o tb_dbg_monitor
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_dbg_monitor 2>&1)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "All tests passed"; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1
